// ==== logic/host_pkg.sv ====
package host_pkg;

	// ------------------------------------------------------------------
	// Host pipe word
	// ------------------------------------------------------------------

	typedef logic [31:0] word_t;

	// FIFO and block sizing, in pipe words
	localparam int FIFO_DEPTH_DEF  = 64;
	localparam int BLOCK_WORDS_DEF = 8;
	localparam int HEADROOM_DEF    = 4;   // Slack for count update latency

	// ------------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------------

	localparam logic [1:0] ADDR_CTRL = 2'd0;   // Enables, clear, mode
	localparam logic [1:0] ADDR_COEF = 2'd1;   // Weight high, bias low

	// Control word bit positions
	localparam int CTRL_READS_EN  = 0;
	localparam int CTRL_WRITES_EN = 1;
	localparam int CTRL_CLEAR     = 2;   // Pulse only
	localparam int CTRL_MODE      = 3;

endpackage

// ==== logic/pool_pkg.sv ====
package pool_pkg;

	// ------------------------------------------------------------------
	// Fixed point types
	// ------------------------------------------------------------------

	typedef logic signed [15:0] pixel_t;    // Q8.8, also the result
	typedef logic signed [15:0] weight_t;   // Q8.8
	typedef logic signed [15:0] bias_t;

	typedef enum logic {
		MODE_MAXPOOL = 1'b0,
		MODE_CONV1X1 = 1'b1
	} mode_t;

	// 3x3 window is the largest one
	localparam int WIN_MAX = 9;

	typedef pixel_t [WIN_MAX-1:0] window_t;

	// Engine configuration as held by the register block
	typedef struct packed {
		logic    reads_en;
		logic    writes_en;
		mode_t   mode;
		weight_t weight;
		bias_t   bias;
	} cfg_t;

endpackage

// ==== logic/window_if.sv ====
`timescale 1ns/1ps

interface window_if;

	logic              req;   // Window offered
	pool_pkg::window_t win;
	logic [3:0]        len;   // 9 or 1 pixels
	logic              ack;   // Result taken

	modport gather (
		output req, win, len,
		input  ack
	);

	modport compute (
		input  req, win, len,
		output ack
	);

endinterface

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T          = logic [31:0],
	parameter int  FIFO_DEPTH = 64
) (
	input  logic                            okClk,
	input  logic                            reset,
	input  logic                            clear,
	input  logic                            wr_en,
	input  T                                wr_data,
	input  logic                            rd_en,
	output T                                rd_data,
	output logic                            full,
	output logic                            empty,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	T                 mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign do_push = wr_en && !full;   // Push into full is dropped
	assign do_pop  = rd_en && !empty;
	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign rd_data = mem[rd_ptr];      // Head shown ahead of the pop

	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge okClk) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
	input  logic            okClk,
	input  logic            reset,
	input  logic            ctrl_wr,
	input  logic [1:0]      ctrl_addr,
	input  host_pkg::word_t ctrl_wdata,
	output pool_pkg::cfg_t  cfg,
	output logic            clear
);

	logic ctrl_sel;
	logic coef_sel;

	// Address decode
	assign ctrl_sel = ctrl_wr && (ctrl_addr == host_pkg::ADDR_CTRL);
	assign coef_sel = ctrl_wr && (ctrl_addr == host_pkg::ADDR_COEF);

	always_ff @(posedge okClk) begin
		if (reset) begin
			cfg   <= '0;   // Reads and writes off, max pooling
			clear <= 1'b0;
		end else begin
			// One cycle pulse, the bit itself is never held
			clear <= ctrl_sel && ctrl_wdata[host_pkg::CTRL_CLEAR];

			if (ctrl_sel) begin
				cfg.reads_en  <= ctrl_wdata[host_pkg::CTRL_READS_EN];
				cfg.writes_en <= ctrl_wdata[host_pkg::CTRL_WRITES_EN];
				cfg.mode      <= pool_pkg::mode_t'(ctrl_wdata[host_pkg::CTRL_MODE]);
			end

			// Weight in the upper half, bias in the lower
			if (coef_sel) begin
				cfg.weight <= ctrl_wdata[31:16];
				cfg.bias   <= ctrl_wdata[15:0];
			end
		end
	end

endmodule

// ==== logic/window_gather.sv ====
`timescale 1ns/1ps

module window_gather (
	input  logic            okClk,
	input  logic            reset,
	input  logic            clear,
	input  pool_pkg::cfg_t  cfg,
	input  logic            in_empty,
	input  host_pkg::word_t in_data,
	output logic            in_pop,
	window_if.gather        win
);

	pool_pkg::window_t win_r;
	logic [3:0]        cnt;          // Pixels taken so far
	logic [3:0]        len_r;
	logic [3:0]        target_len;
	logic [3:0]        cur_len;
	logic              req_r;

	// Length comes from the mode when the first pixel arrives
	assign target_len = (cfg.mode == pool_pkg::MODE_CONV1X1) ? 4'd1 : 4'(pool_pkg::WIN_MAX);
	assign cur_len    = (cnt == 4'd0) ? target_len : len_r;

	// Hold off until the previous window has been fully released
	assign in_pop = cfg.reads_en && !in_empty && !req_r && !win.ack;

	// ------------------------------------------------------------------
	// Pixel shift register
	// ------------------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (in_pop)
			win_r <= {win_r[pool_pkg::WIN_MAX-2:0], pool_pkg::pixel_t'(in_data[15:0])};
	end

	// ------------------------------------------------------------------
	// Counter and request side of the handshake
	// ------------------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (reset || clear) begin
			cnt   <= '0;
			len_r <= 4'(pool_pkg::WIN_MAX);
			req_r <= 1'b0;
		end else begin
			if (in_pop) begin
				if (cnt == 4'd0)
					len_r <= target_len;
				if (cnt == cur_len - 4'd1) begin
					cnt   <= '0;
					req_r <= 1'b1;   // Window complete
				end else begin
					cnt <= cnt + 4'd1;
				end
			end

			if (req_r && win.ack)
				req_r <= 1'b0;
		end
	end

	assign win.req = req_r;
	assign win.win = win_r;
	assign win.len = len_r;

endmodule

// ==== logic/pool_conv_unit.sv ====
`timescale 1ns/1ps

module pool_conv_unit (
	input  logic             okClk,
	input  logic             reset,
	input  logic             clear,
	input  pool_pkg::cfg_t   cfg,
	window_if.compute        win,
	input  logic             out_full,
	output logic             out_push,
	output pool_pkg::pixel_t out_data
);

	logic               ack_r;
	logic               fire;
	pool_pkg::pixel_t   max_l1 [4];
	pool_pkg::pixel_t   max_l2 [2];
	pool_pkg::pixel_t   max_l3;
	pool_pkg::pixel_t   max_res;
	logic signed [31:0] product;
	logic signed [31:0] scaled;
	pool_pkg::pixel_t   conv_res;

	function automatic pool_pkg::pixel_t max2(input pool_pkg::pixel_t a,
	                                          input pool_pkg::pixel_t b);
		return (a > b) ? a : b;   // Signed compare
	endfunction

	// ------------------------------------------------------------------
	// 3x3 max pooling, comparison tree
	// ------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < 4; i++)
			max_l1[i] = max2(win.win[2*i], win.win[2*i+1]);
	end

	assign max_l2[0] = max2(max_l1[0], max_l1[1]);
	assign max_l2[1] = max2(max_l1[2], max_l1[3]);
	assign max_l3    = max2(max_l2[0], max_l2[1]);
	assign max_res   = max2(max_l3, win.win[pool_pkg::WIN_MAX-1]);   // Odd pixel joins last

	// ------------------------------------------------------------------
	// 1x1 convolution
	// ------------------------------------------------------------------

	assign product  = win.win[0] * cfg.weight;   // Q16.16
	assign scaled   = product >>> 8;
	assign conv_res = scaled[15:0] + cfg.bias;   // Wraps at 16 bits

	assign out_data = (win.len == 4'd1) ? conv_res : max_res;

	// ------------------------------------------------------------------
	// Compute side of the handshake
	// ------------------------------------------------------------------

	// Waits with ack low while writes are off or the output is full
	assign fire     = win.req && !ack_r && cfg.writes_en && !out_full;
	assign out_push = fire;

	always_ff @(posedge okClk) begin
		if (reset || clear) begin
			ack_r <= 1'b0;
		end else begin
			if (fire)
				ack_r <= 1'b1;
			else if (!win.req)
				ack_r <= 1'b0;   // Request withdrawn
		end
	end

	assign win.ack = ack_r;

endmodule

// ==== logic/pipe_throttle.sv ====
`timescale 1ns/1ps

module pipe_throttle #(
	parameter int FIFO_DEPTH  = 64,
	parameter int BLOCK_WORDS = 8,
	parameter int HEADROOM    = 4
) (
	input  logic                            okClk,
	input  logic                            reset,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] in_count,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] out_count,
	input  logic                            in_full,
	input  logic                            in_empty,
	input  logic                            out_full,
	input  logic                            out_empty,
	input  pool_pkg::cfg_t                  cfg,
	input  logic                            busy,
	output logic                            pipe_in_ready,
	output logic                            pipe_out_ready,
	output logic [7:0]                      led
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Room for a full block plus slack
	localparam logic [CNT_W-1:0] IN_LIMIT  = CNT_W'(FIFO_DEPTH - HEADROOM - BLOCK_WORDS);
	localparam logic [CNT_W-1:0] OUT_BLOCK = CNT_W'(BLOCK_WORDS);

	always_ff @(posedge okClk) begin
		if (reset) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= (in_count <= IN_LIMIT);
			pipe_out_ready <= (out_count >= OUT_BLOCK);   // Whole block waiting
		end
	end

	// Status LEDs, active high
	assign led = {in_full, in_empty, out_full, out_empty,
	              cfg.writes_en, cfg.reads_en, cfg.mode, busy};

endmodule

// ==== logic/pool_accel_top.sv ====
`timescale 1ns/1ps

module pool_accel_top #(
	parameter int FIFO_DEPTH  = host_pkg::FIFO_DEPTH_DEF,
	parameter int BLOCK_WORDS = host_pkg::BLOCK_WORDS_DEF,
	parameter int HEADROOM    = host_pkg::HEADROOM_DEF
) (
	input  logic            okClk,
	input  logic            reset,
	// Register write
	input  logic            ctrl_wr,
	input  logic [1:0]      ctrl_addr,
	input  host_pkg::word_t ctrl_wdata,
	// Pipe in
	input  logic            pipe_in_write,
	input  host_pkg::word_t pipe_in_data,
	output logic            pipe_in_ready,
	// Pipe out
	input  logic            pipe_out_read,
	output host_pkg::word_t pipe_out_data,
	output logic            pipe_out_ready,
	output logic [7:0]      led
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	pool_pkg::cfg_t   cfg;
	logic             clear;
	logic             in_pop;
	host_pkg::word_t  in_data;
	logic             in_full;
	logic             in_empty;
	logic [CNT_W-1:0] in_count;
	logic             out_push;
	pool_pkg::pixel_t out_data;
	pool_pkg::pixel_t out_head;
	logic             out_full;
	logic             out_empty;
	logic [CNT_W-1:0] out_count;

	window_if win_bus ();

	// ------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------

	ctrl_regs u_ctrl_regs (
		.okClk      (okClk),
		.reset      (reset),
		.ctrl_wr    (ctrl_wr),
		.ctrl_addr  (ctrl_addr),
		.ctrl_wdata (ctrl_wdata),
		.cfg        (cfg),
		.clear      (clear)
	);

	// ------------------------------------------------------------------
	// Pipe FIFOs and compute path
	// ------------------------------------------------------------------

	sync_fifo #(.T(host_pkg::word_t), .FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
		.okClk (okClk), .reset (reset), .clear (clear),
		.wr_en (pipe_in_write), .wr_data (pipe_in_data),
		.rd_en (in_pop), .rd_data (in_data),
		.full (in_full), .empty (in_empty), .count (in_count)
	);

	window_gather u_window_gather (
		.okClk (okClk), .reset (reset), .clear (clear), .cfg (cfg),
		.in_empty (in_empty), .in_data (in_data), .in_pop (in_pop),
		.win (win_bus.gather)
	);

	pool_conv_unit u_pool_conv_unit (
		.okClk (okClk), .reset (reset), .clear (clear), .cfg (cfg),
		.win (win_bus.compute),
		.out_full (out_full), .out_push (out_push), .out_data (out_data)
	);

	sync_fifo #(.T(pool_pkg::pixel_t), .FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
		.okClk (okClk), .reset (reset), .clear (clear),
		.wr_en (out_push), .wr_data (out_data),
		.rd_en (pipe_out_read), .rd_data (out_head),
		.full (out_full), .empty (out_empty), .count (out_count)
	);

	assign pipe_out_data = {16'h0000, out_head};   // Result in the low half

	pipe_throttle #(
		.FIFO_DEPTH (FIFO_DEPTH), .BLOCK_WORDS (BLOCK_WORDS), .HEADROOM (HEADROOM)
	) u_pipe_throttle (
		.okClk (okClk), .reset (reset),
		.in_count (in_count), .out_count (out_count),
		.in_full (in_full), .in_empty (in_empty),
		.out_full (out_full), .out_empty (out_empty),
		.cfg (cfg), .busy (win_bus.req),
		.pipe_in_ready (pipe_in_ready), .pipe_out_ready (pipe_out_ready), .led (led)
	);

endmodule

// ==== test/tb_pool_accel_tasks.svh ====
`ifndef TB_POOL_ACCEL_TASKS_SVH
`define TB_POOL_ACCEL_TASKS_SVH

// ----------------------------------------------------------------------
// Host side bus tasks
// ----------------------------------------------------------------------

task automatic wait_in_ready();
	int cyc;
	cyc = 0;
	@(negedge okClk);
	while (!pipe_in_ready && cyc < TIMEOUT_CYC) begin
		cyc++;
		@(negedge okClk);
	end
	if (!pipe_in_ready) begin
		$display("Timed out waiting for pipe_in_ready to go high");
		to_cnt++;
	end
endtask

task automatic wait_out_ready();
	int cyc;
	cyc = 0;
	@(negedge okClk);
	while (!pipe_out_ready && cyc < TIMEOUT_CYC) begin
		cyc++;
		@(negedge okClk);
	end
	if (!pipe_out_ready) begin
		$display("Timed out waiting for a block on the output pipe");
		to_cnt++;
	end
endtask

// Bit 4 of the LEDs is the output FIFO empty flag
task automatic wait_out_not_empty();
	int cyc;
	cyc = 0;
	@(negedge okClk);
	while (led[4] && cyc < TIMEOUT_CYC) begin
		cyc++;
		@(negedge okClk);
	end
	if (led[4]) begin
		$display("Timed out waiting for a result in the output FIFO");
		to_cnt++;
	end
endtask

task automatic write_reg(input logic [1:0] addr, input host_pkg::word_t data);
	@(posedge okClk);
	ctrl_wr    <= 1'b1;
	ctrl_addr  <= addr;
	ctrl_wdata <= data;
	@(posedge okClk);
	ctrl_wr    <= 1'b0;
endtask

task automatic send_word(input host_pkg::word_t data);
	wait_in_ready();
	@(posedge okClk);
	pipe_in_write <= 1'b1;
	pipe_in_data  <= data;
	@(posedge okClk);
	pipe_in_write <= 1'b0;
endtask

// One block of reads, then let the registered ready catch up
task automatic read_block();
	wait_out_ready();
	@(posedge okClk);
	pipe_out_read <= 1'b1;
	repeat (BLOCK_WORDS) @(posedge okClk);
	pipe_out_read <= 1'b0;
	repeat (2) @(posedge okClk);
endtask

// ----------------------------------------------------------------------
// Typed compares
// ----------------------------------------------------------------------

task automatic check_pixel(input string name, input pool_pkg::pixel_t got,
                           input pool_pkg::pixel_t exp);
	if (got !== exp) begin
		$display("FAILED %s: got %h expected %h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED %s: got %h expected %h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("FAILED led: got %h expected %h", got, exp);
		err_cnt++;
	end
endtask

`endif

// ==== test/tb_pool_accel.sv ====
`timescale 1ns/1ps

module tb_pool_accel;

	localparam int FIFO_DEPTH  = host_pkg::FIFO_DEPTH_DEF;
	localparam int BLOCK_WORDS = host_pkg::BLOCK_WORDS_DEF;
	localparam int HEADROOM    = host_pkg::HEADROOM_DEF;
	localparam int IN_LIMIT    = FIFO_DEPTH - HEADROOM - BLOCK_WORDS;
	localparam int TIMEOUT_CYC = 1000;

	logic            okClk;
	logic            reset;
	logic            ctrl_wr;
	logic [1:0]      ctrl_addr;
	host_pkg::word_t ctrl_wdata;
	logic            pipe_in_write;
	host_pkg::word_t pipe_in_data;
	logic            pipe_in_ready;
	logic            pipe_out_read;
	host_pkg::word_t pipe_out_data;
	logic            pipe_out_ready;
	logic [7:0]      led;

	int                 err_cnt = 0;
	int                 to_cnt  = 0;
	integer             seed    = 32'haacb2495;
	pool_pkg::pixel_t   exp_q [$];   // Expected results in read order
	pool_pkg::window_t  win;
	host_pkg::word_t    w;
	pool_pkg::weight_t  weight;
	pool_pkg::bias_t    bias;
	int                 n;

	`include "tb_pool_accel_tasks.svh"

	pool_accel_top #(
		.FIFO_DEPTH (FIFO_DEPTH), .BLOCK_WORDS (BLOCK_WORDS), .HEADROOM (HEADROOM)
	) u_pool_accel_top (
		.okClk (okClk), .reset (reset),
		.ctrl_wr (ctrl_wr), .ctrl_addr (ctrl_addr), .ctrl_wdata (ctrl_wdata),
		.pipe_in_write (pipe_in_write), .pipe_in_data (pipe_in_data),
		.pipe_in_ready (pipe_in_ready),
		.pipe_out_read (pipe_out_read), .pipe_out_data (pipe_out_data),
		.pipe_out_ready (pipe_out_ready), .led (led)
	);

	// Max of nine pixels, or pixel * weight >>> 8 + bias kept to 16 bits
	function automatic pool_pkg::pixel_t ref_result(input pool_pkg::mode_t mode,
	                                                input pool_pkg::window_t px,
	                                                input pool_pkg::weight_t wt,
	                                                input pool_pkg::bias_t bs);
		pool_pkg::pixel_t   m;
		pool_pkg::pixel_t   p;
		logic signed [31:0] prod;
		logic signed [31:0] shifted;
		if (mode == pool_pkg::MODE_CONV1X1) begin
			p       = px[0];
			prod    = p * wt;
			shifted = prod >>> 8;
			return shifted[15:0] + bs;
		end
		m = px[0];
		for (int i = 1; i < pool_pkg::WIN_MAX; i++) begin
			p = px[i];
			if (p > m)
				m = p;
		end
		return m;
	endfunction

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	// Compare process, head word is stable at the falling edge
	always @(negedge okClk) begin
		if (pipe_out_read === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Result word read while no result was expected");
				err_cnt++;
			end else begin
				check_pixel("pipe_out_data[15:0]", pipe_out_data[15:0], exp_q.pop_front());
				check_pixel("pipe_out_data[31:16]", pipe_out_data[31:16], '0);
			end
		end
	end

	initial begin
		reset         <= 1'b1;
		ctrl_wr       <= 1'b0;
		ctrl_addr     <= '0;
		ctrl_wdata    <= '0;
		pipe_in_write <= 1'b0;
		pipe_in_data  <= '0;
		pipe_out_read <= 1'b0;
		repeat (3) @(posedge okClk);
		reset <= 1'b0;

		// ------------------------------------------------------------------
		// After reset
		// ------------------------------------------------------------------
		@(posedge okClk);   // Ready is registered, one cycle behind
		@(negedge okClk);
		check_bit("pipe_in_ready", pipe_in_ready, 1'b1);
		check_bit("pipe_out_ready", pipe_out_ready, 1'b0);
		check_led(led, 8'h50);   // Both empty bits only

		// 3x3 max pooling, 8 windows
		write_reg(host_pkg::ADDR_CTRL, 32'h3);
		for (int g = 0; g < 8; g++) begin
			for (int i = 0; i < pool_pkg::WIN_MAX; i++) begin
				w      = $random(seed);
				win[i] = w[15:0];
				send_word(w);   // Upper half is ignored by the DUT
			end
			exp_q.push_back(ref_result(pool_pkg::MODE_MAXPOOL, win, '0, '0));
		end
		read_block();

		// 1x1 convolution, last two pixels at the extremes
		w      = $random(seed);
		weight = w[31:16];
		bias   = w[15:0];
		write_reg(host_pkg::ADDR_COEF, w);
		write_reg(host_pkg::ADDR_CTRL, 32'hB);
		for (int i = 0; i < 8; i++) begin
			w = $random(seed);
			if (i == 6)
				w[15:0] = 16'h7fff;
			if (i == 7)
				w[15:0] = 16'h8000;
			win[0] = w[15:0];
			send_word(w);
			exp_q.push_back(ref_result(pool_pkg::MODE_CONV1X1, win, weight, bias));
		end
		read_block();

		// ------------------------------------------------------------------
		// Back-pressure, 16 windows with writes off
		// ------------------------------------------------------------------
		write_reg(host_pkg::ADDR_CTRL, 32'h9);
		for (int i = 0; i < 16; i++) begin
			w      = $random(seed);
			win[0] = w[15:0];
			send_word(w);
			exp_q.push_back(ref_result(pool_pkg::MODE_CONV1X1, win, weight, bias));
		end
		repeat (20) @(posedge okClk);
		@(negedge okClk);
		check_bit("pipe_out_ready", pipe_out_ready, 1'b0);
		check_led(led, 8'h17);   // Reads on, 1x1, busy, input not empty
		write_reg(host_pkg::ADDR_CTRL, 32'hB);
		read_block();
		read_block();

		// One result left unread, the clear has to drop it
		w = $random(seed);
		send_word(w);
		wait_out_not_empty();

		// Throttle with reads off, then clear
		write_reg(host_pkg::ADDR_CTRL, 32'hA);
		n = 0;
		@(negedge okClk);
		while (pipe_in_ready && n < FIFO_DEPTH) begin
			@(posedge okClk);
			pipe_in_write <= 1'b1;
			pipe_in_data  <= host_pkg::word_t'(n);
			n++;
			@(negedge okClk);
		end
		@(posedge okClk);
		pipe_in_write <= 1'b0;
		if (n <= IN_LIMIT || n > IN_LIMIT + 3) begin
			$display("pipe_in_ready fell after %0d writes, limit is %0d", n, IN_LIMIT);
			err_cnt++;
		end
		@(negedge okClk);
		check_led(led, 8'h0A);   // Neither FIFO empty
		write_reg(host_pkg::ADDR_CTRL, 32'h1 << host_pkg::CTRL_CLEAR);
		wait_in_ready();
		check_led(led, 8'h50);
		check_bit("pipe_out_ready", pipe_out_ready, 1'b0);

		if (exp_q.size() != 0) begin
			$display("%0d expected results were never read", exp_q.size());
			err_cnt++;
		end
		$display("Errors: %0d failed check(s), %0d timeout(s)", err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+test
logic/host_pkg.sv
logic/pool_pkg.sv
logic/window_if.sv
logic/sync_fifo.sv
logic/ctrl_regs.sv
logic/window_gather.sv
logic/pool_conv_unit.sv
logic/pipe_throttle.sv
logic/pool_accel_top.sv
test/tb_pool_accel.sv

// ==== Bender.yml ====
package:
  name: pool_accel

sources:
  - logic/host_pkg.sv
  - logic/pool_pkg.sv
  - logic/window_if.sv
  - logic/sync_fifo.sv
  - logic/ctrl_regs.sv
  - logic/window_gather.sv
  - logic/pool_conv_unit.sv
  - logic/pipe_throttle.sv
  - logic/pool_accel_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_pool_accel.sv
